// ==== common/aes_pkg.sv ====
// ============================================================
// AES-128 column core shared definitions
// ============================================================
`default_nettype none

package aes_pkg;

	// ============================================================
	// Widths
	// ============================================================
	typedef logic [7:0]   byte_t;
	typedef logic [31:0]  word_t;
	// Column 0 in the top word, FIPS-197 byte order
	typedef logic [127:0] block_t;
	typedef logic [1:0]   col_idx_t;
	typedef logic [3:0]   round_t;

	// Round and column counts
	localparam round_t NUM_ROUNDS = 4'd10;
	localparam int     COLS       = 4;

	// First round constant, later ones by xtime
	localparam byte_t RCON_INIT = 8'h01;

	// Accept edge to out_valid, in clock edges
	localparam int LATENCY = 54;

	// ============================================================
	// Controller states
	// ============================================================
	typedef enum logic [3:0] {
		IDLE,
		INIT_COL0,
		INIT_COL1,
		INIT_COL2,
		INIT_COL3,
		KEY_STEP,
		ROUND_COL0,
		ROUND_COL1,
		ROUND_COL2,
		ROUND_COL3,
		DONE
	} aes_state_e;

	// Datapath controls from the sequencer
	typedef struct packed {
		logic     load;
		logic     shift_en;
		logic     key_step;
		logic     col_en;
		col_idx_t col_idx;
		// Round 0, plain key addition
		logic     initial_round;
		logic     final_round;
	} ctrl_t;

	// Multiply by x in GF(2^8)
	function automatic byte_t xtime(input byte_t b);
		xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

// ==== control/aes_control.sv ====
// ============================================================
// AES-128 sequencing controller
// ============================================================
`default_nettype none

module aes_control (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    in_valid,
	input  wire logic    out_ready,
	output logic         in_ready,
	output logic         out_valid,
	output aes_pkg::ctrl_t ctrl
);

	aes_pkg::aes_state_e state;
	aes_pkg::aes_state_e next_state;
	aes_pkg::round_t     round;

	// ============================================================
	// State register and next state
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= aes_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			// Wait for a block
			aes_pkg::IDLE:
				if (in_valid)
					next_state = aes_pkg::INIT_COL0;
			// Round 0, key addition column by column
			aes_pkg::INIT_COL0:  next_state = aes_pkg::INIT_COL1;
			aes_pkg::INIT_COL1:  next_state = aes_pkg::INIT_COL2;
			aes_pkg::INIT_COL2:  next_state = aes_pkg::INIT_COL3;
			aes_pkg::INIT_COL3:  next_state = aes_pkg::KEY_STEP;
			// ShiftRows plus g-function word
			aes_pkg::KEY_STEP:   next_state = aes_pkg::ROUND_COL0;
			aes_pkg::ROUND_COL0: next_state = aes_pkg::ROUND_COL1;
			aes_pkg::ROUND_COL1: next_state = aes_pkg::ROUND_COL2;
			aes_pkg::ROUND_COL2: next_state = aes_pkg::ROUND_COL3;
			aes_pkg::ROUND_COL3:
				if (round == aes_pkg::NUM_ROUNDS)
					next_state = aes_pkg::DONE;
				else
					next_state = aes_pkg::KEY_STEP;
			// Hold result until taken
			aes_pkg::DONE:
				if (out_ready)
					next_state = aes_pkg::IDLE;
			default:             next_state = aes_pkg::IDLE;
		endcase
	end

	// Round counter, one step per KEY_STEP
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			round <= '0;
		else if (ctrl.load)
			round <= '0;
		else if (ctrl.key_step)
			round <= round + 1'b1;
	end

	// ============================================================
	// Handshake flags and control decode
	// ============================================================
	assign in_ready  = (state == aes_pkg::IDLE);
	assign out_valid = (state == aes_pkg::DONE);

	always_comb
	begin
		ctrl = '0;
		ctrl.load        = in_ready && in_valid;
		ctrl.final_round = (round == aes_pkg::NUM_ROUNDS);
		case (state)
			aes_pkg::INIT_COL0, aes_pkg::INIT_COL1,
			aes_pkg::INIT_COL2, aes_pkg::INIT_COL3:
			begin
				ctrl.col_en        = 1'b1;
				ctrl.initial_round = 1'b1;
			end
			aes_pkg::KEY_STEP:
			begin
				ctrl.shift_en = 1'b1;
				ctrl.key_step = 1'b1;
			end
			aes_pkg::ROUND_COL0, aes_pkg::ROUND_COL1,
			aes_pkg::ROUND_COL2, aes_pkg::ROUND_COL3:
				ctrl.col_en = 1'b1;
			default:
				ctrl.col_en = 1'b0;
		endcase
		// Column number from the state
		case (state)
			aes_pkg::INIT_COL1, aes_pkg::ROUND_COL1: ctrl.col_idx = 2'd1;
			aes_pkg::INIT_COL2, aes_pkg::ROUND_COL2: ctrl.col_idx = 2'd2;
			aes_pkg::INIT_COL3, aes_pkg::ROUND_COL3: ctrl.col_idx = 2'd3;
			default:                                 ctrl.col_idx = 2'd0;
		endcase
	end

	// Never offering and accepting at once
	assert property (@(posedge clk) disable iff (!rst_n) !(out_valid && in_ready));

	// Result held under back-pressure
	assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> out_valid);

endmodule

`default_nettype wire

// ==== datapath/aes_column_mix.sv ====
// ============================================================
// MixColumns and round key addition
// ============================================================
`default_nettype none

module aes_column_mix (
	input  wire aes_pkg::ctrl_t ctrl,
	input  wire aes_pkg::word_t sub_col,
	input  wire aes_pkg::word_t raw_col,
	input  wire aes_pkg::word_t round_key_word,
	output aes_pkg::word_t      new_col
);

	aes_pkg::word_t sel_col;
	aes_pkg::word_t mix_col;

	// Fixed matrix 02 03 01 01, row 0 is the top byte
	function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t c);
		aes_pkg::byte_t a0;
		aes_pkg::byte_t a1;
		aes_pkg::byte_t a2;
		aes_pkg::byte_t a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		mix_column[31:24] = aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3;
		mix_column[23:16] = a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3;
		mix_column[15:8]  = a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3;
		mix_column[7:0]   = aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3);
	endfunction

	// Round 0 takes the plain column
	assign sel_col = ctrl.initial_round ? raw_col : sub_col;

	// ============================================================
	// Mixing, skipped in rounds 0 and 10
	// ============================================================
	always_comb
	begin
		if (ctrl.initial_round || ctrl.final_round)
			mix_col = sel_col;
		else
			mix_col = mix_column(sel_col);
	end

	// AddRoundKey for this column
	assign new_col = mix_col ^ round_key_word;

endmodule

`default_nettype wire

// ==== datapath/aes_key_schedule.sv ====
// ============================================================
// On-the-fly AES-128 key expansion
// ============================================================
`default_nettype none

module aes_key_schedule (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire aes_pkg::ctrl_t  ctrl,
	input  wire aes_pkg::block_t in_key,
	input  wire aes_pkg::word_t  sub_word,
	output aes_pkg::word_t       key_word,
	output aes_pkg::word_t       key_rot_word
);

	// Current round key, word 0 first
	aes_pkg::word_t w [aes_pkg::COLS];
	aes_pkg::byte_t rcon;

	// Chained word for round columns 1 to 3
	assign key_word = (ctrl.initial_round || ctrl.col_idx == 2'd0) ? w[ctrl.col_idx]
		: w[ctrl.col_idx] ^ w[ctrl.col_idx - 2'd1];

	// RotWord of word 3 for the g-function
	assign key_rot_word = {w[3][23:0], w[3][31:24]};

	// ============================================================
	// Key word updates
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (ctrl.load)
		begin
			for (int i = 0; i < aes_pkg::COLS; i++)
				w[i] <= in_key[127 - 32 * i -: 32];
		end
		else if (ctrl.key_step)
			w[0] <= w[0] ^ sub_word ^ {rcon, 24'h000000};
		else if (ctrl.col_en && !ctrl.initial_round && ctrl.col_idx != 2'd0)
			w[ctrl.col_idx] <= key_word;
	end

	// Round constant, doubled after each use
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcon <= aes_pkg::RCON_INIT;
		else if (ctrl.load)
			rcon <= aes_pkg::RCON_INIT;
		else if (ctrl.key_step)
			rcon <= aes_pkg::xtime(rcon);
	end

endmodule

`default_nettype wire

// ==== datapath/aes_sbox_lane.sv ====
// ============================================================
// Forward S-box byte lane
// ============================================================
`default_nettype none

module aes_sbox_lane (
	input  wire aes_pkg::byte_t sub_in,
	output aes_pkg::byte_t      sub_out
);

	// FIPS-197 forward table, entry 0 first, one row per high nibble
	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Pure lookup, no clock
	assign sub_out = SBOX[sub_in];

endmodule

`default_nettype wire

// ==== datapath/aes_state_store.sv ====
// ============================================================
// AES state register and S-box operand select
// ============================================================
`default_nettype none

module aes_state_store (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire aes_pkg::ctrl_t  ctrl,
	input  wire aes_pkg::block_t in_block,
	input  wire aes_pkg::word_t  key_rot_word,
	input  wire aes_pkg::word_t  new_col,
	output aes_pkg::word_t       sbox_in,
	output aes_pkg::word_t       raw_col,
	output aes_pkg::block_t      out_block
);

	aes_pkg::block_t st;

	// Row r rotates left by r columns
	function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t b);
		aes_pkg::block_t r;
		for (int c = 0; c < aes_pkg::COLS; c++)
		begin
			for (int row = 0; row < 4; row++)
				r[127 - 8 * (4 * c + row) -: 8] =
					b[127 - 8 * (4 * ((c + row) % aes_pkg::COLS) + row) -: 8];
		end
		return r;
	endfunction

	// ============================================================
	// State update
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (ctrl.load)
			st <= in_block;
		else if (ctrl.shift_en)
			st <= shift_rows(st);
		else if (ctrl.col_en)
			st[127 - 32 * int'(ctrl.col_idx) -: 32] <= new_col;
	end

	// Selected column, unsubstituted
	assign raw_col = st[127 - 32 * int'(ctrl.col_idx) -: 32];

	// Lanes serve the g-function on key steps
	assign sbox_in = ctrl.key_step ? key_rot_word : raw_col;

	assign out_block = st;

	// State only moves on an enable
	assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.load || ctrl.shift_en || ctrl.col_en) |=> $stable(out_block));

endmodule

`default_nettype wire

// ==== hdl/aes_core.sv ====
// ============================================================
// AES-128 column-serial encryption core
// ============================================================
`default_nettype none

module aes_core (
	input  wire logic            clk,
	input  wire logic            rst_n,
	// Input block and key
	input  wire logic            in_valid,
	output logic                 in_ready,
	input  wire aes_pkg::block_t in_block,
	input  wire aes_pkg::block_t in_key,
	// Ciphertext
	output logic                 out_valid,
	input  wire logic            out_ready,
	output aes_pkg::block_t      out_block
);

	aes_pkg::ctrl_t ctrl;
	aes_pkg::word_t sbox_in;
	aes_pkg::word_t sbox_out;
	aes_pkg::word_t raw_col;
	aes_pkg::word_t new_col;
	aes_pkg::word_t key_word;
	aes_pkg::word_t key_rot_word;

	// ============================================================
	// Sequencer
	// ============================================================
	aes_control u_control (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_ready (out_ready),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.ctrl      (ctrl)
	);

	// ============================================================
	// Datapath
	// ============================================================
	aes_state_store u_state (
		.clk          (clk),
		.rst_n        (rst_n),
		.ctrl         (ctrl),
		.in_block     (in_block),
		.key_rot_word (key_rot_word),
		.new_col      (new_col),
		.sbox_in      (sbox_in),
		.raw_col      (raw_col),
		.out_block    (out_block)
	);

	// Shared S-box, one lane per byte
	for (genvar i = 0; i < aes_pkg::COLS; i++)
	begin : g_lane
		aes_sbox_lane u_lane (
			.sub_in  (sbox_in[8 * i +: 8]),
			.sub_out (sbox_out[8 * i +: 8])
		);
	end

	aes_column_mix u_mix (
		.ctrl           (ctrl),
		.sub_col        (sbox_out),
		.raw_col        (raw_col),
		.round_key_word (key_word),
		.new_col        (new_col)
	);

	// Key words march with the columns
	aes_key_schedule u_key (
		.clk          (clk),
		.rst_n        (rst_n),
		.ctrl         (ctrl),
		.in_key       (in_key),
		.sub_word     (sbox_out),
		.key_word     (key_word),
		.key_rot_word (key_rot_word)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_aes_core -f sources.f -o tb_aes_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_aes_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0

// ==== sources.f ====
common/aes_pkg.sv
datapath/aes_sbox_lane.sv
datapath/aes_column_mix.sv
datapath/aes_state_store.sv
datapath/aes_key_schedule.sv
control/aes_control.sv
hdl/aes_core.sv
verification/tb_clock_gen.sv
verification/tb_aes_core.sv

// ==== verification/tb_aes_core.sv ====
// ============================================================
// AES-128 core testbench
// ============================================================
`default_nettype none

module tb_aes_core;

	localparam int NUM_VEC      = 4;
	localparam int MAX_STALL    = 8;
	localparam int RESET_CYCLES = 10;
	// Per block budget plus reset
	localparam int TIMEOUT_CYCLES =
		NUM_VEC * (aes_pkg::LATENCY + MAX_STALL + 10) + RESET_CYCLES;

	// One known-answer entry
	typedef struct packed {
		aes_pkg::block_t key;
		aes_pkg::block_t plain;
		aes_pkg::block_t cipher;
		logic [7:0]      stall;
	} vector_t;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic            in_ready;
	aes_pkg::block_t in_block;
	aes_pkg::block_t in_key;
	logic            out_valid;
	logic            out_ready;
	aes_pkg::block_t out_block;

	vector_t     vectors [NUM_VEC];
	logic [31:0] rng;
	int          errors;
	int          checks;

	tb_clock_gen u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	aes_core dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_block  (in_block),
		.in_key    (in_key),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_block (out_block)
	);

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// FIPS-197 and SP 800-38A ECB vectors
	task automatic load_table();
		vectors[0].key    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		vectors[0].plain  = 128'h3243f6a8885a308d313198a2e0370734;
		vectors[0].cipher = 128'h3925841d02dc09fbdc118597196a0b32;
		vectors[1].key    = 128'h000102030405060708090a0b0c0d0e0f;
		vectors[1].plain  = 128'h00112233445566778899aabbccddeeff;
		vectors[1].cipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		vectors[2].key    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		vectors[2].plain  = 128'h6bc1bee22e409f96e93d7e117393172a;
		vectors[2].cipher = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
		vectors[3].key    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		vectors[3].plain  = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
		vectors[3].cipher = 128'hf5d3d58503b9699de785895a96fdbaaf;
		// Stall of 1 to MAX_STALL cycles per block
		for (int k = 0; k < NUM_VEC; k++)
		begin
			rng = xorshift32(rng);
			vectors[k].stall = 8'(1 + rng % MAX_STALL);
		end
	endtask

	// ============================================================
	// One block entered just after a rising edge
	// ============================================================
	task automatic run_block(input vector_t v);
		int cycles;
		in_valid <= 1'b1;
		in_block <= v.plain;
		in_key   <= v.key;
		@(negedge clk);
		check_value("in_ready", 128'(in_ready), 128'd1);
		while (!in_ready)
			@(negedge clk);
		// Accept edge
		@(posedge clk);
		in_valid <= 1'b0;
		rng = xorshift32(rng);
		// Scrambled inputs so the core relies on its own copy
		in_block <= {4{rng}};
		in_key   <= ~{4{rng}};
		cycles = 0;
		@(negedge clk);
		while (!out_valid)
		begin
			check_value("in_ready", 128'(in_ready), 128'd0);
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		check_value("latency", 128'(cycles), 128'(aes_pkg::LATENCY));
		check_value("out_block", out_block, v.cipher);
		// Back-pressure
		repeat (v.stall)
		begin
			@(posedge clk);
			@(negedge clk);
			check_value("out_valid", 128'(out_valid), 128'd1);
			check_value("out_block", out_block, v.cipher);
			check_value("in_ready", 128'(in_ready), 128'd0);
		end
		@(posedge clk);
		out_ready <= 1'b1;
		@(negedge clk);
		check_value("out_valid", 128'(out_valid), 128'd1);
		check_value("out_block", out_block, v.cipher);
		check_value("in_ready", 128'(in_ready), 128'd0);
		// Transfer edge
		@(posedge clk);
		out_ready <= 1'b0;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial
	begin
		in_valid  = 1'b0;
		in_block  = '0;
		in_key    = '0;
		out_ready = 1'b0;
		errors    = 0;
		checks    = 0;
		rng       = 32'h6936;
		load_table();
		@(posedge rst_n);
		@(negedge clk);
		check_value("in_ready", 128'(in_ready), 128'd1);
		check_value("out_valid", 128'(out_valid), 128'd0);
		@(posedge clk);
		// Next block offered right after each transfer
		for (int k = 0; k < NUM_VEC; k++)
			run_block(vectors[k]);
		@(negedge clk);
		check_value("out_valid", 128'(out_valid), 128'd0);
		check_value("in_ready", 128'(in_ready), 128'd1);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// ============================================================
// Testbench clock and reset
// ============================================================
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// Period of 8 time units
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held low for 10 rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire
